// File: verilog/eth_traffic_pkg.sv
// shared widths, register map and data pattern, imported by every traffic controller module
`default_nettype none

package eth_traffic_pkg;

	// two channel regions in the address map
	localparam int NUM_CHANNELS = 2;

	typedef logic [63:0] data_t;
	typedef logic [2:0]  empty_t;
	typedef logic [5:0]  rx_err_t;
	typedef logic [13:0] addr_t;
	typedef logic [1:0]  region_t;
	typedef logic [11:0] offset_t;
	typedef logic [31:0] word_t;
	typedef logic [15:0] pkt_cnt_t;
	typedef logic [10:0] pkt_len_t;
	typedef logic [2:0]  reg_idx_t;

	//////////////////////////////
	// address regions, region 0 is an unmapped hole
	localparam region_t REGION_SEL = 2'd1;
	localparam region_t REGION_CH0 = 2'd2;
	localparam region_t REGION_CH1 = 2'd3;

	// register index is offset bits 4:2
	localparam reg_idx_t REG_CTRL      = 3'd0;
	localparam reg_idx_t REG_PKT_COUNT = 3'd1;
	localparam reg_idx_t REG_PKT_LEN   = 3'd2;
	localparam reg_idx_t REG_TX_SENT   = 3'd3;
	localparam reg_idx_t REG_RX_GOOD   = 3'd4;
	localparam reg_idx_t REG_RX_BAD    = 3'd5;

	//////////////////////////////
	localparam logic [31:0] PATTERN_TAG = 32'h5A3C_0F96;

	typedef enum logic {IDLE, SEND} gen_state_t;

	// tag high, packet number and word number low
	function automatic data_t pattern_word(input pkt_cnt_t pkt, input pkt_len_t word);
		return {PATTERN_TAG, pkt, 5'd0, word};
	endfunction

endpackage

`default_nettype wire

// File: verilog/traffic_csr_decoder.sv
// avalon-mm region decoder, routes accesses to the channel controllers and holds the selector
`default_nettype none

module traffic_csr_decoder (
	input  wire                                                        clk,
	input  wire                                                        arst_n,
	input  wire                                                        mm_read,
	input  wire                                                        mm_write,
	input  wire eth_traffic_pkg::addr_t                                mm_address,
	input  wire eth_traffic_pkg::word_t                                mm_writedata,
	output eth_traffic_pkg::word_t                                     mm_readdata,
	output logic                                                       mm_waitrequest,
	output logic                   [eth_traffic_pkg::NUM_CHANNELS-1:0] ch_read,
	output logic                   [eth_traffic_pkg::NUM_CHANNELS-1:0] ch_write,
	output eth_traffic_pkg::offset_t                                   ch_offset,
	input  wire eth_traffic_pkg::word_t [eth_traffic_pkg::NUM_CHANNELS-1:0] ch_readdata,
	output logic                                                       std_sel
);
	import eth_traffic_pkg::*;

	localparam region_t CH_REGION [NUM_CHANNELS] = '{REGION_CH0, REGION_CH1};

	region_t                 region;
	logic [NUM_CHANNELS-1:0] ch_hit;
	logic                    sel_hit;

	assign region    = mm_address[13:12];
	assign ch_offset = mm_address[11:0];
	assign sel_hit   = (region == REGION_SEL);

	// every register answers in the same cycle
	assign mm_waitrequest = 1'b0;

	always_comb
	begin
		for (int i = 0; i < NUM_CHANNELS; i++)
		begin
			ch_hit[i]   = (region == CH_REGION[i]);
			ch_read[i]  = mm_read & ch_hit[i];
			ch_write[i] = mm_write & ch_hit[i];
		end
	end

	// region 0 and anything unmatched read as zero
	always_comb
	begin
		mm_readdata = '0;
		if (sel_hit)
			mm_readdata = {31'd0, std_sel};
		for (int i = 0; i < NUM_CHANNELS; i++)
		begin
			if (ch_hit[i])
				mm_readdata = ch_readdata[i];
		end
	end

	//////////////////////////////
	// traffic selector, 1 picks standard traffic
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			std_sel <= 1'b0;
		else if (mm_write && sel_hit)
			std_sel <= mm_writedata[0];
	end

endmodule

`default_nettype wire

// File: verilog/avl_st_sel.sv
// per-channel avalon-st selector between the standard controller and the MAC ports
`default_nettype none

module avl_st_sel (
	input  wire                              std_sel,
	input  wire eth_traffic_pkg::data_t      ctl_tx_data,
	input  wire eth_traffic_pkg::empty_t     ctl_tx_empty,
	input  wire                              ctl_tx_sop,
	input  wire                              ctl_tx_eop,
	input  wire                              ctl_tx_val,
	output logic                             ctl_tx_ready,
	output eth_traffic_pkg::data_t           ctl_rx_data,
	output eth_traffic_pkg::empty_t          ctl_rx_empty,
	output eth_traffic_pkg::rx_err_t         ctl_rx_error,
	output logic                             ctl_rx_sop,
	output logic                             ctl_rx_eop,
	output logic                             ctl_rx_val,
	input  wire                              ctl_rx_ready,
	output eth_traffic_pkg::data_t           mac_tx_data,
	output eth_traffic_pkg::empty_t          mac_tx_empty,
	output logic                             mac_tx_sop,
	output logic                             mac_tx_eop,
	output logic                             mac_tx_val,
	input  wire                              mac_tx_ready,
	input  wire eth_traffic_pkg::data_t      mac_rx_data,
	input  wire eth_traffic_pkg::empty_t     mac_rx_empty,
	input  wire eth_traffic_pkg::rx_err_t    mac_rx_error,
	input  wire                              mac_rx_sop,
	input  wire                              mac_rx_eop,
	input  wire                              mac_rx_val,
	output logic                             mac_rx_ready
);
	import eth_traffic_pkg::*;

	// transmit side idles when standard traffic is not selected
	assign mac_tx_data  = std_sel ? ctl_tx_data : data_t'(0);
	assign mac_tx_empty = std_sel ? ctl_tx_empty : empty_t'(0);
	assign mac_tx_sop   = std_sel & ctl_tx_sop;
	assign mac_tx_eop   = std_sel & ctl_tx_eop;
	assign mac_tx_val   = std_sel & ctl_tx_val;
	assign ctl_tx_ready = std_sel & mac_tx_ready;

	// receive side drains into nowhere when deselected
	assign ctl_rx_data  = mac_rx_data;
	assign ctl_rx_empty = mac_rx_empty;
	assign ctl_rx_error = mac_rx_error;
	assign ctl_rx_sop   = mac_rx_sop;
	assign ctl_rx_eop   = mac_rx_eop;
	assign ctl_rx_val   = std_sel & mac_rx_val;
	assign mac_rx_ready = std_sel ? ctl_rx_ready : 1'b1;

endmodule

`default_nettype wire

// File: verilog/pkt_gen.sv
// packet generator, sends pkt_count packets of pkt_len bytes carrying the counted pattern
`default_nettype none

module pkt_gen (
	input  wire                              clk,
	input  wire                              arst_n,
	input  wire                              start,
	input  wire eth_traffic_pkg::pkt_cnt_t   pkt_count,
	input  wire eth_traffic_pkg::pkt_len_t   pkt_len,
	output eth_traffic_pkg::data_t           tx_data,
	output eth_traffic_pkg::empty_t          tx_empty,
	output logic                             tx_sop,
	output logic                             tx_eop,
	output logic                             tx_val,
	input  wire                              tx_ready,
	output eth_traffic_pkg::pkt_cnt_t        tx_sent
);
	import eth_traffic_pkg::*;

	gen_state_t state;
	logic       pend;
	pkt_cnt_t   count_q;
	pkt_cnt_t   pkt_idx;
	pkt_len_t   beats_q;
	pkt_len_t   word_idx;
	empty_t     empty_q;
	logic       fire;
	logic       last_word;
	logic       last_pkt;

	assign fire      = tx_val & tx_ready;
	assign last_word = (word_idx == pkt_len_t'(beats_q - 1'b1));
	assign last_pkt  = (pkt_idx == pkt_cnt_t'(count_q - 1'b1));

	// beat outputs come straight from the counters, so a stall holds them
	assign tx_val   = (state == SEND);
	assign tx_data  = pattern_word(pkt_idx, word_idx);
	assign tx_sop   = tx_val & (word_idx == '0);
	assign tx_eop   = tx_val & last_word;
	assign tx_empty = tx_eop ? empty_q : empty_t'(0);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= IDLE;
			pend     <= 1'b0;
			count_q  <= '0;
			pkt_idx  <= '0;
			beats_q  <= '0;
			word_idx <= '0;
			empty_q  <= '0;
			tx_sent  <= '0;
		end
		else
		begin
			pend <= 1'b0;
			// latch the run, beats is ceil(len/8)
			if (start && state == IDLE && !pend)
			begin
				count_q <= pkt_count;
				beats_q <= pkt_len_t'(({1'b0, pkt_len} + 12'd7) >> 3);
				empty_q <= empty_t'(3'd0 - pkt_len[2:0]);
				tx_sent <= '0;
				pend    <= (pkt_count != '0);
			end
			if (pend)
			begin
				state    <= SEND;
				pkt_idx  <= '0;
				word_idx <= '0;
			end
			if (fire)
			begin
				if (last_word)
				begin
					word_idx <= '0;
					pkt_idx  <= pkt_idx + 1'b1;
					tx_sent  <= tx_sent + 1'b1;
					if (last_pkt)
						state <= IDLE;
				end
				else
					word_idx <= word_idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/pkt_mon.sv
// packet monitor, checks received packets against the pattern and counts good and bad ones
`default_nettype none

module pkt_mon (
	input  wire                              clk,
	input  wire                              arst_n,
	input  wire                              start,
	input  wire eth_traffic_pkg::pkt_cnt_t   pkt_count,
	input  wire eth_traffic_pkg::pkt_len_t   pkt_len,
	input  wire                              stop_mon,
	input  wire eth_traffic_pkg::data_t      rx_data,
	input  wire eth_traffic_pkg::empty_t     rx_empty,
	input  wire eth_traffic_pkg::rx_err_t    rx_error,
	input  wire                              rx_sop,
	input  wire                              rx_eop,
	input  wire                              rx_val,
	output logic                             rx_ready,
	output eth_traffic_pkg::pkt_cnt_t        rx_good,
	output eth_traffic_pkg::pkt_cnt_t        rx_bad,
	output logic                             mon_active,
	output logic                             mon_done,
	output logic                             mon_error
);
	import eth_traffic_pkg::*;

	pkt_cnt_t count_q;
	pkt_cnt_t seen;
	pkt_len_t beats_q;
	pkt_len_t word_idx;
	empty_t   empty_q;
	logic     bad_acc;
	logic     fire;
	logic     last_word;
	logic     beat_bad;
	logic     len_bad;
	logic     pkt_bad;

	assign rx_ready  = mon_active;
	assign fire      = rx_val & mon_active;
	assign seen      = rx_good + rx_bad;
	assign last_word = (word_idx == pkt_len_t'(beats_q - 1'b1));

	// expected packet number is what has arrived so far
	assign beat_bad = (rx_data != pattern_word(seen, word_idx)) || (rx_error != '0) ||
		(rx_sop != (word_idx == '0));
	// eop early or late, or a wrong empty
	assign len_bad  = rx_eop ? (!last_word || rx_empty != empty_q) : last_word;
	assign pkt_bad  = bad_acc | beat_bad | len_bad;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			count_q    <= '0;
			beats_q    <= '0;
			empty_q    <= '0;
			word_idx   <= '0;
			bad_acc    <= 1'b0;
			rx_good    <= '0;
			rx_bad     <= '0;
			mon_active <= 1'b0;
			mon_done   <= 1'b0;
			mon_error  <= 1'b0;
		end
		else
		begin
			if (start && !mon_active)
			begin
				count_q    <= pkt_count;
				beats_q    <= pkt_len_t'(({1'b0, pkt_len} + 12'd7) >> 3);
				empty_q    <= empty_t'(3'd0 - pkt_len[2:0]);
				word_idx   <= '0;
				bad_acc    <= 1'b0;
				rx_good    <= '0;
				rx_bad     <= '0;
				mon_active <= (pkt_count != '0);
				mon_done   <= 1'b0;
				mon_error  <= 1'b0;
			end
			else if (fire)
			begin
				if (rx_eop)
				begin
					word_idx <= '0;
					bad_acc  <= 1'b0;
					if (pkt_bad)
					begin
						rx_bad    <= rx_bad + 1'b1;
						mon_error <= 1'b1;
					end
					else
						rx_good <= rx_good + 1'b1;
					// last packet of the run
					if (pkt_cnt_t'(seen + 1'b1) == count_q)
					begin
						mon_active <= 1'b0;
						mon_done   <= 1'b1;
					end
				end
				else
				begin
					word_idx <= word_idx + 1'b1;
					bad_acc  <= pkt_bad;
				end
			end
			if (stop_mon)
				mon_active <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/eth_std_traffic_controller.sv
// standard traffic controller for one channel, CSR block around a packet generator and monitor
`default_nettype none

module eth_std_traffic_controller (
	input  wire                              clk,
	input  wire                              arst_n,
	input  wire                              csr_read,
	input  wire                              csr_write,
	input  wire eth_traffic_pkg::offset_t    csr_offset,
	input  wire eth_traffic_pkg::word_t      csr_writedata,
	output eth_traffic_pkg::word_t           csr_readdata,
	output eth_traffic_pkg::data_t           tx_data,
	output eth_traffic_pkg::empty_t          tx_empty,
	output logic                             tx_sop,
	output logic                             tx_eop,
	output logic                             tx_val,
	input  wire                              tx_ready,
	input  wire eth_traffic_pkg::data_t      rx_data,
	input  wire eth_traffic_pkg::empty_t     rx_empty,
	input  wire eth_traffic_pkg::rx_err_t    rx_error,
	input  wire                              rx_sop,
	input  wire                              rx_eop,
	input  wire                              rx_val,
	output logic                             rx_ready,
	input  wire                              stop_mon,
	output logic                             mon_active,
	output logic                             mon_done,
	output logic                             mon_error
);
	import eth_traffic_pkg::*;

	reg_idx_t idx;
	pkt_cnt_t pkt_count;
	pkt_len_t pkt_len;
	logic     start;
	pkt_cnt_t tx_sent;
	pkt_cnt_t rx_good;
	pkt_cnt_t rx_bad;

	assign idx = csr_offset[4:2];

	//////////////////////////////
	// run parameters and start pulse
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pkt_count <= '0;
			pkt_len   <= 11'd64;
			start     <= 1'b0;
		end
		else
		begin
			start <= csr_write && (idx == REG_CTRL) && csr_writedata[0];
			if (csr_write && idx == REG_PKT_COUNT)
				pkt_count <= csr_writedata[15:0];
			if (csr_write && idx == REG_PKT_LEN)
				pkt_len <= csr_writedata[10:0];
		end
	end

	// ctrl reads back the monitor status bits
	always_comb
	begin
		csr_readdata = '0;
		if (csr_read)
		begin
			case (idx)
				REG_CTRL:      csr_readdata = {29'd0, mon_error, mon_done, mon_active};
				REG_PKT_COUNT: csr_readdata = {16'd0, pkt_count};
				REG_PKT_LEN:   csr_readdata = {21'd0, pkt_len};
				REG_TX_SENT:   csr_readdata = {16'd0, tx_sent};
				REG_RX_GOOD:   csr_readdata = {16'd0, rx_good};
				REG_RX_BAD:    csr_readdata = {16'd0, rx_bad};
				default:       csr_readdata = '0;
			endcase
		end
	end

	pkt_gen gen_u0 (
		.clk (clk), .arst_n (arst_n), .start (start),
		.pkt_count (pkt_count), .pkt_len (pkt_len),
		.tx_data (tx_data), .tx_empty (tx_empty), .tx_sop (tx_sop),
		.tx_eop (tx_eop), .tx_val (tx_val), .tx_ready (tx_ready),
		.tx_sent (tx_sent)
	);

	pkt_mon mon_u0 (
		.clk (clk), .arst_n (arst_n), .start (start),
		.pkt_count (pkt_count), .pkt_len (pkt_len), .stop_mon (stop_mon),
		.rx_data (rx_data), .rx_empty (rx_empty), .rx_error (rx_error),
		.rx_sop (rx_sop), .rx_eop (rx_eop), .rx_val (rx_val), .rx_ready (rx_ready),
		.rx_good (rx_good), .rx_bad (rx_bad),
		.mon_active (mon_active), .mon_done (mon_done), .mon_error (mon_error)
	);

endmodule

`default_nettype wire

// File: verilog/eth_traffic_controller_top.sv
// ethernet traffic controller top, bus decoder plus one standard controller and selector per MAC
`default_nettype none

module eth_traffic_controller_top (
	input  wire                                                         clk,
	input  wire                                                         arst_n,
	input  wire                                                         mm_read,
	input  wire                                                         mm_write,
	input  wire eth_traffic_pkg::addr_t                                 mm_address,
	input  wire eth_traffic_pkg::word_t                                 mm_writedata,
	output eth_traffic_pkg::word_t                                      mm_readdata,
	output logic                                                        mm_waitrequest,
	output eth_traffic_pkg::data_t   [eth_traffic_pkg::NUM_CHANNELS-1:0] tx_data,
	output eth_traffic_pkg::empty_t  [eth_traffic_pkg::NUM_CHANNELS-1:0] tx_empty,
	output logic                     [eth_traffic_pkg::NUM_CHANNELS-1:0] tx_sop,
	output logic                     [eth_traffic_pkg::NUM_CHANNELS-1:0] tx_eop,
	output logic                     [eth_traffic_pkg::NUM_CHANNELS-1:0] tx_val,
	input  wire                      [eth_traffic_pkg::NUM_CHANNELS-1:0] tx_ready,
	input  wire eth_traffic_pkg::data_t   [eth_traffic_pkg::NUM_CHANNELS-1:0] rx_data,
	input  wire eth_traffic_pkg::empty_t  [eth_traffic_pkg::NUM_CHANNELS-1:0] rx_empty,
	input  wire eth_traffic_pkg::rx_err_t [eth_traffic_pkg::NUM_CHANNELS-1:0] rx_error,
	input  wire                      [eth_traffic_pkg::NUM_CHANNELS-1:0] rx_sop,
	input  wire                      [eth_traffic_pkg::NUM_CHANNELS-1:0] rx_eop,
	input  wire                      [eth_traffic_pkg::NUM_CHANNELS-1:0] rx_val,
	output logic                     [eth_traffic_pkg::NUM_CHANNELS-1:0] rx_ready,
	input  wire                      [eth_traffic_pkg::NUM_CHANNELS-1:0] stop_mon,
	output logic                     [eth_traffic_pkg::NUM_CHANNELS-1:0] mon_active,
	output logic                     [eth_traffic_pkg::NUM_CHANNELS-1:0] mon_done,
	output logic                     [eth_traffic_pkg::NUM_CHANNELS-1:0] mon_error
);
	import eth_traffic_pkg::*;

	logic                     std_sel;
	logic [NUM_CHANNELS-1:0]  ch_read;
	logic [NUM_CHANNELS-1:0]  ch_write;
	offset_t                  ch_offset;
	word_t [NUM_CHANNELS-1:0] ch_readdata;

	traffic_csr_decoder csr_dec_u0 (
		.clk            (clk),
		.arst_n         (arst_n),
		.mm_read        (mm_read),
		.mm_write       (mm_write),
		.mm_address     (mm_address),
		.mm_writedata   (mm_writedata),
		.mm_readdata    (mm_readdata),
		.mm_waitrequest (mm_waitrequest),
		.ch_read        (ch_read),
		.ch_write       (ch_write),
		.ch_offset      (ch_offset),
		.ch_readdata    (ch_readdata),
		.std_sel        (std_sel)
	);

	for (genvar i = 0; i < NUM_CHANNELS; i++)
	begin : g_chan
		// controller side of the selector
		data_t   c_tx_data;
		empty_t  c_tx_empty;
		logic    c_tx_sop;
		logic    c_tx_eop;
		logic    c_tx_val;
		logic    c_tx_ready;
		data_t   c_rx_data;
		empty_t  c_rx_empty;
		rx_err_t c_rx_error;
		logic    c_rx_sop;
		logic    c_rx_eop;
		logic    c_rx_val;
		logic    c_rx_ready;

		eth_std_traffic_controller std_ctrl_u (
			.clk (clk), .arst_n (arst_n),
			.csr_read (ch_read[i]), .csr_write (ch_write[i]),
			.csr_offset (ch_offset), .csr_writedata (mm_writedata),
			.csr_readdata (ch_readdata[i]),
			.tx_data (c_tx_data), .tx_empty (c_tx_empty), .tx_sop (c_tx_sop),
			.tx_eop (c_tx_eop), .tx_val (c_tx_val), .tx_ready (c_tx_ready),
			.rx_data (c_rx_data), .rx_empty (c_rx_empty), .rx_error (c_rx_error),
			.rx_sop (c_rx_sop), .rx_eop (c_rx_eop), .rx_val (c_rx_val),
			.rx_ready (c_rx_ready),
			.stop_mon (stop_mon[i]), .mon_active (mon_active[i]),
			.mon_done (mon_done[i]), .mon_error (mon_error[i])
		);

		avl_st_sel st_sel_u (
			.std_sel (std_sel),
			.ctl_tx_data (c_tx_data), .ctl_tx_empty (c_tx_empty), .ctl_tx_sop (c_tx_sop),
			.ctl_tx_eop (c_tx_eop), .ctl_tx_val (c_tx_val), .ctl_tx_ready (c_tx_ready),
			.ctl_rx_data (c_rx_data), .ctl_rx_empty (c_rx_empty), .ctl_rx_error (c_rx_error),
			.ctl_rx_sop (c_rx_sop), .ctl_rx_eop (c_rx_eop), .ctl_rx_val (c_rx_val),
			.ctl_rx_ready (c_rx_ready),
			.mac_tx_data (tx_data[i]), .mac_tx_empty (tx_empty[i]), .mac_tx_sop (tx_sop[i]),
			.mac_tx_eop (tx_eop[i]), .mac_tx_val (tx_val[i]), .mac_tx_ready (tx_ready[i]),
			.mac_rx_data (rx_data[i]), .mac_rx_empty (rx_empty[i]), .mac_rx_error (rx_error[i]),
			.mac_rx_sop (rx_sop[i]), .mac_rx_eop (rx_eop[i]), .mac_rx_val (rx_val[i]),
			.mac_rx_ready (rx_ready[i])
		);
	end

endmodule

`default_nettype wire

// File: sim/tb_eth_traffic_properties.sv
// bound assertions on the stream and bus outputs of the traffic controller top, see the bind at the end
`default_nettype none

module tb_eth_traffic_properties (
	input wire                                                          clk,
	input wire                                                          arst_n,
	input wire eth_traffic_pkg::data_t [eth_traffic_pkg::NUM_CHANNELS-1:0] tx_data,
	input wire                        [eth_traffic_pkg::NUM_CHANNELS-1:0] tx_sop,
	input wire                        [eth_traffic_pkg::NUM_CHANNELS-1:0] tx_eop,
	input wire                        [eth_traffic_pkg::NUM_CHANNELS-1:0] tx_val,
	input wire                        [eth_traffic_pkg::NUM_CHANNELS-1:0] tx_ready,
	input wire                                                          mm_waitrequest
);
	timeunit 1ns;
	timeprecision 1ps;

	import eth_traffic_pkg::*;

	for (genvar i = 0; i < NUM_CHANNELS; i++)
	begin : g_chan
		// no traffic while in reset
		a_idle_in_reset: assert property (@(posedge clk) !arst_n |-> !tx_val[i])
			else $error("tx_val high during reset on channel %0d", i);

		// a stalled beat stays put
		a_hold_beat: assert property (@(posedge clk) disable iff (!arst_n)
			tx_val[i] && !tx_ready[i] |=> tx_val[i] && $stable(tx_data[i]) &&
			$stable(tx_sop[i]) && $stable(tx_eop[i]))
			else $error("stalled beat changed on channel %0d", i);
	end

	a_no_wait: assert property (@(posedge clk) !mm_waitrequest)
		else $error("waitrequest went high");

endmodule

bind eth_traffic_controller_top tb_eth_traffic_properties i_props (
	.clk            (clk),
	.arst_n         (arst_n),
	.tx_data        (tx_data),
	.tx_sop         (tx_sop),
	.tx_eop         (tx_eop),
	.tx_val         (tx_val),
	.tx_ready       (tx_ready),
	.mm_waitrequest (mm_waitrequest)
);

`default_nettype wire

// File: sim/tb_eth_traffic.sv
// testbench driving the traffic controller top through a MAC loopback model with random stalls
`default_nettype none

module tb_eth_traffic;
	timeunit 1ns;
	timeprecision 1ps;

	import eth_traffic_pkg::*;

	logic                     clk = 1'b0;
	logic                     arst_n = 1'b0;
	logic                     mm_read = 1'b0;
	logic                     mm_write = 1'b0;
	addr_t                    mm_address = '0;
	word_t                    mm_writedata = '0;
	word_t                    mm_readdata;
	logic                     mm_waitrequest;
	data_t   [NUM_CHANNELS-1:0] tx_data;
	empty_t  [NUM_CHANNELS-1:0] tx_empty;
	logic    [NUM_CHANNELS-1:0] tx_sop;
	logic    [NUM_CHANNELS-1:0] tx_eop;
	logic    [NUM_CHANNELS-1:0] tx_val;
	logic    [NUM_CHANNELS-1:0] tx_ready = '0;
	data_t   [NUM_CHANNELS-1:0] rx_data = '0;
	empty_t  [NUM_CHANNELS-1:0] rx_empty = '0;
	rx_err_t [NUM_CHANNELS-1:0] rx_error = '0;
	logic    [NUM_CHANNELS-1:0] rx_sop = '0;
	logic    [NUM_CHANNELS-1:0] rx_eop = '0;
	logic    [NUM_CHANNELS-1:0] rx_val = '0;
	logic    [NUM_CHANNELS-1:0] rx_ready;
	logic    [NUM_CHANNELS-1:0] stop_mon = '0;
	logic    [NUM_CHANNELS-1:0] mon_active;
	logic    [NUM_CHANNELS-1:0] mon_done;
	logic    [NUM_CHANNELS-1:0] mon_error;

	// loopback beat is {sop, eop, empty, data}
	logic [68:0] beat_q [NUM_CHANNELS][$];
	int          run_len [NUM_CHANNELS];
	int          exp_pkt [NUM_CHANNELS];
	int          exp_word [NUM_CHANNELS];
	int          rx_pkt [NUM_CHANNELS];
	int          inject_pkt [NUM_CHANNELS] = '{-1, -1};
	logic [31:0] lfsr = 32'h2281_1a2e;

	eth_traffic_controller_top i_eth_traffic_controller_top (.*);

	always #10 clk = ~clk;

	// Fibonacci taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic fail(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
			fail("value check failed");
		end
	endtask

	function automatic addr_t reg_addr(input region_t r, input reg_idx_t idx);
		return {r, 7'd0, idx, 2'd0};
	endfunction

	function automatic region_t ch_region(input int ch);
		return (ch == 0) ? REGION_CH0 : REGION_CH1;
	endfunction

	task automatic bus_write(input addr_t a, input word_t d);
		@(posedge clk);
		mm_write <= 1'b1;
		mm_address <= a;
		mm_writedata <= d;
		@(posedge clk);
		mm_write <= 1'b0;
	endtask

	task automatic bus_read(input addr_t a, output word_t d);
		@(posedge clk);
		mm_read <= 1'b1;
		mm_address <= a;
		@(posedge clk);
		d = mm_readdata;
		mm_read <= 1'b0;
	endtask

	task automatic start_run(input int ch, input int count, input int len);
		bus_write(reg_addr(ch_region(ch), REG_PKT_COUNT), word_t'(count));
		bus_write(reg_addr(ch_region(ch), REG_PKT_LEN), word_t'(len));
		run_len[ch] = len;
		exp_pkt[ch] = 0;
		exp_word[ch] = 0;
		rx_pkt[ch] = 0;
		bus_write(reg_addr(ch_region(ch), REG_CTRL), 32'd1);
		// start pulse and the clearing of the old done flag
		repeat (3) @(posedge clk);
	endtask

	task automatic wait_done(input int ch);
		int n;
		n = 0;
		while (!mon_done[ch])
		begin
			@(posedge clk);
			n++;
			if (n > 20000)
				fail("timeout waiting for mon_done");
		end
	endtask

	task automatic check_counts(input int ch, input int good, input int bad, input int sent);
		word_t d;
		bus_read(reg_addr(ch_region(ch), REG_TX_SENT), d);
		check("tx_sent", 64'(d), 64'(sent));
		bus_read(reg_addr(ch_region(ch), REG_RX_GOOD), d);
		check("rx_good", 64'(d), 64'(good));
		bus_read(reg_addr(ch_region(ch), REG_RX_BAD), d);
		check("rx_bad", 64'(d), 64'(bad));
		check("mon_error", 64'(mon_error[ch]), 64'(bad != 0));
	endtask

	//////////////////////////////
	// MAC model checks tx beats and loops them back on rx
	always @(posedge clk)
	begin
		logic [31:0] r;
		logic [68:0] b;
		int          beats;
		logic        busy;
		if (arst_n)
		begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++)
			begin
				beats = (run_len[ch] + 7) / 8;
				if (tx_val[ch] && tx_ready[ch])
				begin
					check("tx_data", tx_data[ch],
						{PATTERN_TAG, exp_pkt[ch][15:0], exp_word[ch][15:0]});
					check("tx_sop", 64'(tx_sop[ch]), 64'(exp_word[ch] == 0));
					check("tx_eop", 64'(tx_eop[ch]), 64'(exp_word[ch] == beats - 1));
					if (tx_eop[ch])
						check("tx_empty", 64'(tx_empty[ch]), 64'(beats * 8 - run_len[ch]));
					beat_q[ch].push_back({tx_sop[ch], tx_eop[ch], tx_empty[ch], tx_data[ch]});
					if (exp_word[ch] == beats - 1)
					begin
						exp_word[ch] = 0;
						exp_pkt[ch]++;
					end
					else
						exp_word[ch]++;
				end
				rand_bits(2, r);
				tx_ready[ch] <= (r[1:0] != 2'd0);

				busy = rx_val[ch] && !rx_ready[ch];
				if (rx_val[ch] && rx_ready[ch] && rx_eop[ch])
					rx_pkt[ch]++;
				if (!busy)
				begin
					rand_bits(1, r);
					if (beat_q[ch].size() > 0 && r[0])
					begin
						b = beat_q[ch].pop_front();
						{rx_sop[ch], rx_eop[ch], rx_empty[ch], rx_data[ch]} <= b;
						rx_error[ch] <= (rx_pkt[ch] == inject_pkt[ch]) ? 6'h04 : 6'h00;
						rx_val[ch] <= 1'b1;
					end
					else
						rx_val[ch] <= 1'b0;
				end
			end
		end
	end

	initial
	begin
		word_t       d;
		logic [31:0] r;
		int          cnt [NUM_CHANNELS];
		int          n;
		for (int ch = 0; ch < NUM_CHANNELS; ch++)
			run_len[ch] = 8;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);

		// register access
		for (int ch = 0; ch < NUM_CHANNELS; ch++)
		begin
			rand_bits(16, r);
			bus_write(reg_addr(ch_region(ch), REG_PKT_COUNT), r);
			bus_read(reg_addr(ch_region(ch), REG_PKT_COUNT), d);
			check("pkt_count readback", 64'(d), 64'(r[15:0]));
			rand_bits(11, r);
			bus_write(reg_addr(ch_region(ch), REG_PKT_LEN), r);
			bus_read(reg_addr(ch_region(ch), REG_PKT_LEN), d);
			check("pkt_len readback", 64'(d), 64'(r[10:0]));
		end
		bus_write(reg_addr(REGION_SEL, REG_CTRL), 32'hFFFF_FFFF);
		bus_read(reg_addr(REGION_SEL, REG_CTRL), d);
		check("selector readback", 64'(d), 64'd1);
		bus_write(reg_addr(REGION_SEL, REG_CTRL), 32'h0000_0000);
		bus_read(reg_addr(REGION_SEL, REG_CTRL), d);
		check("selector readback", 64'(d), 64'd0);
		bus_write(reg_addr(2'd0, REG_PKT_COUNT), 32'hDEAD_BEEF);
		bus_read(reg_addr(2'd0, REG_PKT_COUNT), d);
		check("region 0 read", 64'(d), 64'd0);

		// deselected receive side drains even with the monitor idle
		check("rx_ready deselected idle", 64'(rx_ready[0]), 64'd1);

		// deselected channel stays quiet until selected
		start_run(0, 2, 20);
		for (int i = 0; i < 20; i++)
		begin
			@(posedge clk);
			check("tx_val deselected", 64'(tx_val[0]), 64'd0);
			check("rx_ready deselected", 64'(rx_ready[0]), 64'd1);
		end
		bus_write(reg_addr(REGION_SEL, REG_CTRL), 32'd1);
		bus_write(reg_addr(REGION_CH0, REG_CTRL), 32'd1);
		n = 0;
		while (!tx_val[0])
		begin
			@(posedge clk);
			n++;
			if (n > 100)
				fail("timeout waiting for tx_val after select");
		end
		wait_done(0);
		check_counts(0, 2, 0, 2);

		// random runs on both channels with back-pressure
		for (int round = 0; round < 4; round++)
		begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++)
			begin
				rand_bits(3, r);
				cnt[ch] = 1 + int'(r[2:0]);
				rand_bits(8, r);
				start_run(ch, cnt[ch], 8 + int'(r[7:0]) % 193);
			end
			for (int ch = 0; ch < NUM_CHANNELS; ch++)
			begin
				wait_done(ch);
				check_counts(ch, cnt[ch], 0, cnt[ch]);
			end
		end

		// receive error on packet 1 of channel 1
		inject_pkt[1] = 1;
		start_run(1, 4, 45);
		wait_done(1);
		check_counts(1, 3, 1, 4);
		inject_pkt[1] = -1;

		// stop the monitor mid-run
		start_run(0, 20, 300);
		n = 0;
		while (rx_pkt[0] < 1)
		begin
			@(posedge clk);
			n++;
			if (n > 2000)
				fail("timeout waiting for first looped packet");
		end
		check("mon_active before stop", 64'(mon_active[0]), 64'd1);
		stop_mon[0] <= 1'b1;
		@(posedge clk);
		stop_mon[0] <= 1'b0;
		@(posedge clk);
		check("mon_active after stop", 64'(mon_active[0]), 64'd0);
		check("mon_done after stop", 64'(mon_done[0]), 64'd0);
		// selected and out of a run, the monitor no longer accepts beats
		check("rx_ready after stop", 64'(rx_ready[0]), 64'd0);

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
verilog/eth_traffic_pkg.sv
verilog/traffic_csr_decoder.sv
verilog/avl_st_sel.sv
verilog/pkt_gen.sv
verilog/pkt_mon.sv
verilog/eth_std_traffic_controller.sv
verilog/eth_traffic_controller_top.sv
sim/tb_eth_traffic_properties.sv
sim/tb_eth_traffic.sv

// File: run.sh
#!/bin/bash
# builds the testbench with Verilator, runs it and scans the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_eth_traffic \
	-o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

if grep -q "Test FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation passed"
exit 0
